//--- hdl/coreDataPort.sv
//========================================
// Core data port
// Local RAM access with alignment, remote requests to fabric
//========================================
module coreDataPort
    import tilePkg::*;
(
    input  logic             Clock,
    input  logic             rstN,
    input  tileId_t          localTileId,
    input  coreReq_t         coreReq,
    input  logic             reqFull,           // Request queue full
    input  logic             inFabricValid,
    input  tileTrans_t       inFabric,
    // RAM port A
    output logic [WordW-1:0] ramAddr,           // Byte address
    output logic [WordW-1:0] ramWrData,
    output logic [3:0]       ramByteEn,
    output logic             ramWrEn,
    input  logic [WordW-1:0] ramRdData,
    // Request queue
    output logic             reqPush,
    output tileTrans_t       reqTrans,
    // Core response
    output logic [WordW-1:0] dmemRdRsp,
    output logic             dmemReady
);

    logic             isLocal;
    logic             remoteAcc;
    logic             setOutstanding;
    logic             outstanding;              // Remote read in flight
    logic             rspValid;
    logic             rspValidQ;
    logic [WordW-1:0] rspDataQ;
    logic [1:0]       adrsLowQ;

    // Tile zero aliases the local tile
    assign isLocal   = (coreReq.address[31:24] == localTileId) ||
                       (coreReq.address[31:24] == 8'h00);
    assign remoteAcc = (coreReq.wrEn || coreReq.rdEn) && !isLocal;

    // Stall on a pending read or a full queue
    assign dmemReady = !outstanding && !reqFull;

    //========================================
    // Local access, RAM port A
    //========================================
    assign ramAddr   = coreReq.address;
    assign ramWrEn   = coreReq.wrEn && isLocal;
    assign ramWrData = coreReq.wrData << {coreReq.address[1:0], 3'b000};
    assign ramByteEn = coreReq.byteEn << coreReq.address[1:0];

    always_ff @(posedge Clock) begin
        adrsLowQ <= coreReq.address[1:0];       // Aligns the read word
        rspDataQ <= inFabric.data;
    end

    //========================================
    // Remote access
    //========================================
    assign reqPush        = remoteAcc && dmemReady;
    assign setOutstanding = reqPush && coreReq.rdEn && !coreReq.wrEn;
    assign rspValid       = outstanding && inFabricValid && (inFabric.opcode == RdRsp);

    always_comb begin
        reqTrans.address     = coreReq.address;
        reqTrans.data        = coreReq.wrData;
        reqTrans.opcode      = coreReq.wrEn ? Wr : Rd;
        reqTrans.requestorId = localTileId;     // Response routes back here
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            outstanding <= 1'b0;
            rspValidQ   <= 1'b0;
        end else begin
            rspValidQ <= rspValid;
            if (rspValid) begin
                outstanding <= 1'b0;            // Response closes the read
            end else if (setOutstanding) begin
                outstanding <= 1'b1;
            end
        end
    end

    // Fabric data wins, else shifted RAM word
    assign dmemRdRsp = rspValidQ ? rspDataQ : (ramRdData >> {adrsLowQ, 3'b000});

endmodule

//--- hdl/dualPortRam.sv
//========================================
// Dual port data RAM
// Word array, byte write enables on both ports
//========================================
module dualPortRam #(
    parameter int DmemAdrsMsb = 11              // Top byte address bit
) (
    input  logic                   Clock,
    // Port A
    input  logic [DmemAdrsMsb-2:0] addrA,       // Word index
    input  logic [31:0]            wrDataA,
    input  logic [3:0]             byteEnA,
    input  logic                   wrEnA,
    output logic [31:0]            rdDataA,
    // Port B
    input  logic [DmemAdrsMsb-2:0] addrB,       // Word index
    input  logic [31:0]            wrDataB,
    input  logic [3:0]             byteEnB,
    input  logic                   wrEnB,
    output logic [31:0]            rdDataB
);

    localparam int Words = 2 ** (DmemAdrsMsb - 1);

    logic [31:0] mem [Words];

    // Both ports in one process, B lands last on a collision
    always_ff @(posedge Clock) begin
        rdDataA <= mem[addrA];                  // Old data on read during write
        rdDataB <= mem[addrB];
        for (int i = 0; i < 4; i++) begin
            if (wrEnA && byteEnA[i]) begin
                mem[addrA][8*i +: 8] <= wrDataA[8*i +: 8];
            end
            if (wrEnB && byteEnB[i]) begin
                mem[addrB][8*i +: 8] <= wrDataB[8*i +: 8];
            end
        end
    end

endmodule

//--- hdl/fabricEgressArb.sv
//========================================
// Fabric egress arbiter
// Round robin between response and request queues
//========================================
module fabricEgressArb
    import tilePkg::*;
(
    input  logic       Clock,
    input  logic       rstN,
    input  logic       fabReady,
    input  tileTrans_t rspHead,
    input  tileTrans_t reqHead,
    input  logic       rspEmpty,
    input  logic       reqEmpty,
    output logic       rspPop,
    output logic       reqPop,
    output logic       outFabricValid,
    output tileTrans_t outFabric
);

    logic rspCand;
    logic reqCand;
    logic grantRsp;
    logic grantReq;
    logic lastWasReq;                           // Last winner, 1 for request queue

    // No candidate while the fabric pushes back
    assign rspCand = !rspEmpty && fabReady;
    assign reqCand = !reqEmpty && fabReady;

    // Prefer the queue that lost last time
    assign grantRsp = rspCand && (!reqCand || lastWasReq);
    assign grantReq = reqCand && !grantRsp;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            lastWasReq <= 1'b1;                 // Responses go first after reset
        end else if (grantRsp || grantReq) begin
            lastWasReq <= grantReq;
        end
    end

    assign rspPop         = grantRsp;
    assign reqPop         = grantReq;
    assign outFabricValid = grantRsp || grantReq;
    assign outFabric      = grantRsp ? rspHead :
                            grantReq ? reqHead :
                                       '0;

endmodule

//--- hdl/fabricSlave.sv
//========================================
// Fabric slave
// Fabric writes and reads to the data region
//========================================
module fabricSlave
    import tilePkg::*;
(
    input  logic             Clock,
    input  logic             rstN,
    input  tileId_t          localTileId,
    input  logic             inFabricValid,
    input  tileTrans_t       inFabric,
    // RAM port B
    output logic [WordW-1:0] ramAddr,
    output logic [WordW-1:0] ramWrData,
    output logic             ramWrEn,
    input  logic [WordW-1:0] ramRdData,
    // Response queue
    output logic             rspPush,
    output tileTrans_t       rspTrans
);

    logic             regionHit;
    logic             rdReq;
    logic             hitQ;
    logic [WordW-1:0] rspAddrQ;

    // Region field strictly inside the bounds
    assign regionHit = (inFabric.address[RegionMsb:RegionLsb] > DmemRegionFloor) &&
                       (inFabric.address[RegionMsb:RegionLsb] < DmemRegionRoof);

    assign ramAddr   = inFabric.address;
    assign ramWrData = inFabric.data;           // Full word only
    assign ramWrEn   = inFabricValid && regionHit && (inFabric.opcode == Wr);
    assign rdReq     = inFabricValid && (inFabric.opcode == Rd);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            rspPush <= 1'b0;
        end else begin
            rspPush <= rdReq;                   // Push one cycle after request
        end
    end

    // Response header, address points back at the requester
    always_ff @(posedge Clock) begin
        hitQ     <= regionHit;
        rspAddrQ <= {inFabric.requestorId, inFabric.address[23:0]};
    end

    always_comb begin
        rspTrans.address     = rspAddrQ;
        rspTrans.data        = hitQ ? ramRdData : '0;   // Miss reads zero
        rspTrans.opcode      = RdRsp;
        rspTrans.requestorId = localTileId;
    end

endmodule

//--- hdl/tileMemWrap.sv
//========================================
// Tile data memory wrapper
// Core port, fabric slave, egress queues and arbiter
//========================================
module tileMemWrap
    import tilePkg::*;
#(
    parameter int DmemAdrsMsb = 11,             // 1024 words
    parameter int FifoDepth   = 2
) (
    input  logic             Clock,
    input  logic             rstN,
    input  tileId_t          localTileId,
    // Core
    input  coreReq_t         coreReq,
    output logic [WordW-1:0] dmemRdRsp,
    output logic             dmemReady,
    // Fabric in
    input  logic             inFabricValid,
    input  tileTrans_t       inFabric,
    output logic             miniCoreReady,
    // Fabric out
    output logic             outFabricValid,
    output tileTrans_t       outFabric,
    input  logic             fabReady
);

    logic [WordW-1:0] coreRamAddr;
    logic [WordW-1:0] coreRamWrData;
    logic [3:0]       coreRamByteEn;
    logic             coreRamWrEn;
    logic [WordW-1:0] coreRamRdData;
    logic [WordW-1:0] fabRamAddr;
    logic [WordW-1:0] fabRamWrData;
    logic             fabRamWrEn;
    logic [WordW-1:0] fabRamRdData;
    logic             rspPush;
    logic             reqPush;
    logic             rspPop;
    logic             reqPop;
    logic             rspEmpty;
    logic             reqEmpty;
    logic             reqFull;
    logic             rspAlmostFull;
    tileTrans_t       rspTrans;
    tileTrans_t       reqTrans;
    tileTrans_t       rspHead;
    tileTrans_t       reqHead;

    //========================================
    // Shared data RAM
    //========================================
    dualPortRam #(.DmemAdrsMsb(DmemAdrsMsb)) dmem (
        .Clock   (Clock),
        .addrA   (coreRamAddr[DmemAdrsMsb:2]),  // Core side
        .wrDataA (coreRamWrData),
        .byteEnA (coreRamByteEn),
        .wrEnA   (coreRamWrEn),
        .rdDataA (coreRamRdData),
        .addrB   (fabRamAddr[DmemAdrsMsb:2]),   // Fabric side
        .wrDataB (fabRamWrData),
        .byteEnB (4'b1111),
        .wrEnB   (fabRamWrEn),
        .rdDataB (fabRamRdData)
    );

    coreDataPort corePort (
        .Clock, .rstN, .localTileId, .coreReq, .reqFull,
        .inFabricValid, .inFabric,
        .ramAddr   (coreRamAddr),
        .ramWrData (coreRamWrData),
        .ramByteEn (coreRamByteEn),
        .ramWrEn   (coreRamWrEn),
        .ramRdData (coreRamRdData),
        .reqPush, .reqTrans, .dmemRdRsp, .dmemReady
    );

    fabricSlave fabSlave (
        .Clock, .rstN, .localTileId, .inFabricValid, .inFabric,
        .ramAddr   (fabRamAddr),
        .ramWrData (fabRamWrData),
        .ramWrEn   (fabRamWrEn),
        .ramRdData (fabRamRdData),
        .rspPush, .rspTrans
    );

    //========================================
    // Egress queues and arbiter
    //========================================
    transFifo #(.FifoDepth(FifoDepth)) rspQueue (
        .Clock, .rstN, .push(rspPush), .pushData(rspTrans), .pop(rspPop),
        .popData(rspHead), .full(), .almostFull(rspAlmostFull), .empty(rspEmpty)
    );

    transFifo #(.FifoDepth(FifoDepth)) reqQueue (
        .Clock, .rstN, .push(reqPush), .pushData(reqTrans), .pop(reqPop),
        .popData(reqHead), .full(reqFull), .almostFull(), .empty(reqEmpty)
    );

    fabricEgressArb egressArb (
        .Clock, .rstN, .fabReady, .rspHead, .reqHead, .rspEmpty, .reqEmpty,
        .rspPop, .reqPop, .outFabricValid, .outFabric
    );

    // One entry margin covers the response push delay
    assign miniCoreReady = !rspAlmostFull;

endmodule

//--- hdl/tilePkg.sv
//========================================
// Tile memory package
// Fabric transaction types, opcodes and address fields
//========================================
package tilePkg;

    // Data path
    localparam int WordW = 32;                  // Core and fabric word width

    typedef logic [7:0] tileId_t;               // Held in address[31:24]

    // Fabric opcodes
    typedef enum logic [1:0] {
        Rd    = 2'd0,                           // Read request
        Wr    = 2'd1,                           // Write request
        RdRsp = 2'd2                            // Read response
    } opcode_e;

    // One fabric transaction, 74 bits
    typedef struct packed {
        logic [WordW-1:0] address;
        logic [WordW-1:0] data;
        opcode_e          opcode;
        tileId_t          requestorId;          // Sender tile
    } tileTrans_t;

    // One core data request, 70 bits
    typedef struct packed {
        logic [WordW-1:0] address;              // Byte address
        logic [WordW-1:0] wrData;               // Right aligned
        logic [3:0]       byteEn;               // Right aligned
        logic             wrEn;
        logic             rdEn;
    } coreReq_t;

    //========================================
    // Fabric address map
    //========================================
    localparam int RegionMsb = 23;              // Region select field
    localparam int RegionLsb = 16;

    // Exclusive bounds, only region 1 hits
    localparam logic [7:0] DmemRegionFloor = 8'h00;
    localparam logic [7:0] DmemRegionRoof  = 8'h02;

endpackage

//--- hdl/transFifo.sv
//========================================
// Transaction FIFO
// Circular buffer of fabric transactions
//========================================
module transFifo
    import tilePkg::*;
#(
    parameter int FifoDepth = 2
) (
    input  logic       Clock,
    input  logic       rstN,
    input  logic       push,
    input  tileTrans_t pushData,
    input  logic       pop,
    output tileTrans_t popData,                 // Head, combinational
    output logic       full,
    output logic       almostFull,              // At most one entry free
    output logic       empty
);

    localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
    localparam int CntW = $clog2(FifoDepth + 1);

    tileTrans_t      store [FifoDepth];         // Payload, no reset
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            doPush;
    logic            doPop;

    assign doPush = push && !full;              // Drop on overflow
    assign doPop  = pop && !empty;

    // Flags from the occupancy count
    assign full       = (count == CntW'(FifoDepth));
    assign almostFull = (count >= CntW'(FifoDepth - 1));
    assign empty      = (count == '0);
    assign popData    = store[rdPtr];

    always_ff @(posedge Clock) begin
        if (doPush) begin
            store[wrPtr] <= pushData;
        end
    end

    //========================================
    // Pointers and count
    //========================================
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PtrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PtrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle or push with pop
            endcase
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the tile memory testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tileMemTb -f vlog.f -o tileMemSim
simOut=$(./obj_dir/tileMemSim)
echo "$simOut"
if echo "$simOut" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- test/tileMemTb.sv
//========================================
// Tile memory wrapper testbench
// Directed tests against a reference data memory
//========================================
module tileMemTb
    import tilePkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int      ClkPeriod     = 40;
    localparam int      NumTests      = 6;
    localparam int      CyclesPerTest = 300;
    localparam int      WatchdogNs    = NumTests * CyclesPerTest * ClkPeriod;
    localparam int      WaitLimit     = 20;     // Cycles before a wait gives up
    localparam tileId_t LocalId       = 8'h05;
    localparam tileId_t RemoteId      = 8'h09;

    logic             Clock;
    logic             rstN;
    tileId_t          localTileId;
    coreReq_t         coreReq;
    logic [WordW-1:0] dmemRdRsp;
    logic             dmemReady;
    logic             inFabricValid;
    tileTrans_t       inFabric;
    logic             miniCoreReady;
    logic             outFabricValid;
    tileTrans_t       outFabric;
    logic             fabReady;

    logic [31:0] refMem [1024];                 // Reference data memory
    logic [9:0]  usedIdx [8];                   // Words with known content
    tileTrans_t  outQ [$];                      // Everything seen on outFabric
    tileTrans_t  expRsp [$];
    tileTrans_t  expReq [$];
    logic        sawValidStalled;
    integer      seed;
    int          errors;
    string       curTest;

    tileMemWrap uut (
        .Clock, .rstN, .localTileId, .coreReq, .dmemRdRsp, .dmemReady,
        .inFabricValid, .inFabric, .miniCoreReady, .outFabricValid, .outFabric, .fabReady
    );

    always #(ClkPeriod / 2) Clock = ~Clock;

    // Output monitor, one transaction taken per valid cycle
    always @(posedge Clock) begin
        if (rstN && outFabricValid) begin
            outQ.push_back(outFabric);
            if (!fabReady) sawValidStalled = 1'b1;
        end
    end

    //========================================
    // Compare tasks and reference model
    //========================================
    task automatic checkWord(input string what, input logic [WordW-1:0] exp,
                             input logic [WordW-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s expected %h actual %h", curTest, what, exp, act);
            errors++;
        end
    endtask

    task automatic checkTrans(input string what, input tileTrans_t exp, input tileTrans_t act);
        if (act !== exp) begin
            $display("FAIL %s %s expected %h actual %h", curTest, what, exp, act);
            errors++;
        end
    endtask

    task automatic checkBit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s %s expected %b actual %b", curTest, what, exp, act);
            errors++;
        end
    endtask

    // Byte k of the core data lands in byte k+lo
    function automatic logic [31:0] mergeWrite(input logic [31:0] word, input logic [31:0] data,
                                               input logic [3:0] be, input logic [1:0] lo);
        logic [31:0] res;
        res = word;
        for (int k = 0; k < 4; k++) begin
            if (be[k] && (k + int'(lo)) < 4) res[8*(k+int'(lo)) +: 8] = data[8*k +: 8];
        end
        return res;
    endfunction

    // Read word moved down by lo bytes, zero filled
    function automatic logic [31:0] alignRead(input logic [31:0] word, input logic [1:0] lo);
        logic [31:0] res;
        res = '0;
        for (int k = 0; k < 4; k++) begin
            if ((k + int'(lo)) < 4) res[8*k +: 8] = word[8*(k+int'(lo)) +: 8];
        end
        return res;
    endfunction

    function automatic tileTrans_t makeTrans(input logic [31:0] addr, input logic [31:0] data,
                                             input opcode_e op, input tileId_t id);
        tileTrans_t t;
        t.address     = addr;
        t.data        = data;
        t.opcode      = op;
        t.requestorId = id;
        return t;
    endfunction

    function automatic logic [31:0] coreAddr(input tileId_t tile, input logic [9:0] idx,
                                             input logic [1:0] lo);
        return {tile, 12'h000, idx, lo};
    endfunction

    function automatic logic [31:0] fabAddr(input logic [7:0] region, input logic [9:0] idx);
        return {8'h77, region, 4'h0, idx, 2'b00};   // Top byte ignored by the slave
    endfunction

    //========================================
    // Drive tasks, all start and end on a falling edge
    //========================================
    task automatic driveCore(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be, input logic wr, input logic rd,
                             output logic [31:0] got);
        int n;
        n = 0;
        while (!dmemReady && n < WaitLimit) begin
            @(negedge Clock);
            n++;
        end
        if (!dmemReady) begin
            $display("dmemReady stayed low before a core request in %s", curTest);
            errors++;
        end
        coreReq = '{address: addr, wrData: data, byteEn: be, wrEn: wr, rdEn: rd};
        @(negedge Clock);
        got     = dmemRdRsp;                    // One cycle after the request
        coreReq = '0;
    endtask

    task automatic sendFabric(input tileTrans_t t);
        int n;
        n = 0;
        while (!miniCoreReady && n < WaitLimit) begin
            @(negedge Clock);
            n++;
        end
        if (!miniCoreReady) begin
            $display("miniCoreReady stayed low before a fabric transfer in %s", curTest);
            errors++;
        end
        inFabricValid = 1'b1;
        inFabric      = t;
        @(negedge Clock);
        inFabricValid = 1'b0;
        inFabric      = '0;
    endtask

    task automatic waitOutput(input int count, input string what);
        int n;
        n = 0;
        while (outQ.size() < count && n < WaitLimit) begin
            @(negedge Clock);
            n++;
        end
        if (outQ.size() < count) begin
            $display("The %s did not appear on outFabric in %s", what, curTest);
            errors++;
        end
    endtask

    //========================================
    // Tests
    //========================================
    task automatic testLocalAccess();
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] got;
        logic [1:0]  lo;
        tileId_t     tile;
        curTest = "localAccess";
        for (int w = 0; w < 8; w++) begin
            r          = $random(seed);
            usedIdx[w] = r[9:0];
            tile       = w[0] ? 8'h00 : LocalId;    // Tile zero is also local
            data       = $random(seed);
            driveCore(coreAddr(tile, usedIdx[w], 2'd0), data, 4'hF, 1'b1, 1'b0, got);
            refMem[usedIdx[w]] = data;
            for (int n = 0; n < 4; n++) begin
                r    = $random(seed);
                lo   = r[1:0];
                data = $random(seed);
                driveCore(coreAddr(tile, usedIdx[w], lo), data, r[7:4], 1'b1, 1'b0, got);
                refMem[usedIdx[w]] = mergeWrite(refMem[usedIdx[w]], data, r[7:4], lo);
                r = $random(seed);
                driveCore(coreAddr(tile, usedIdx[w], r[1:0]), '0, 4'h0, 1'b0, 1'b1, got);
                checkWord("read data", alignRead(refMem[usedIdx[w]], r[1:0]), got);
            end
        end
    endtask

    task automatic testFabricWrite();
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] got;
        curTest = "fabricWrite";
        r    = $random(seed);
        data = $random(seed);
        sendFabric(makeTrans(fabAddr(8'h01, r[9:0]), data, Wr, 8'h21));
        refMem[r[9:0]] = data;
        driveCore(coreAddr(LocalId, r[9:0], 2'd0), '0, 4'h0, 1'b0, 1'b1, got);
        checkWord("core read back", data, got);
    endtask

    task automatic testFabricRead();
        logic [31:0] addr;
        curTest = "fabricRead";
        addr = fabAddr(8'h01, usedIdx[4]);
        sendFabric(makeTrans(addr, '0, Rd, 8'h33));
        waitOutput(1, "hit response");
        if (outQ.size() > 0) begin
            checkTrans("hit response", makeTrans({8'h33, addr[23:0]}, refMem[usedIdx[4]],
                       RdRsp, LocalId), outQ.pop_front());
        end
        addr = fabAddr(8'h03, usedIdx[4]);      // Region 3 misses
        sendFabric(makeTrans(addr, '0, Rd, 8'h34));
        waitOutput(1, "miss response");
        if (outQ.size() > 0) begin
            checkTrans("miss response", makeTrans({8'h34, addr[23:0]}, '0, RdRsp, LocalId),
                       outQ.pop_front());
        end
    endtask

    task automatic testRemoteWrite();
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] got;
        curTest = "remoteWrite";
        addr = coreAddr(RemoteId, usedIdx[0], 2'd0);
        data = $random(seed);
        driveCore(addr, data, 4'hF, 1'b1, 1'b0, got);
        waitOutput(1, "remote write request");
        if (outQ.size() > 0) checkTrans("request", makeTrans(addr, data, Wr, LocalId),
                                        outQ.pop_front());
        driveCore(coreAddr(LocalId, usedIdx[0], 2'd0), '0, 4'h0, 1'b0, 1'b1, got);
        checkWord("RAM unchanged", refMem[usedIdx[0]], got);
    endtask

    task automatic testRemoteRead();
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] got;
        curTest = "remoteRead";
        addr = coreAddr(RemoteId, usedIdx[2], 2'd0);
        driveCore(addr, '0, 4'hF, 1'b0, 1'b1, got);
        checkBit("dmemReady after request", 1'b0, dmemReady);
        waitOutput(1, "remote read request");
        if (outQ.size() > 0) checkTrans("request", makeTrans(addr, '0, Rd, LocalId),
                                        outQ.pop_front());
        repeat (3) @(negedge Clock);
        checkBit("dmemReady while waiting", 1'b0, dmemReady);
        data = $random(seed);
        sendFabric(makeTrans({LocalId, 24'h0}, data, RdRsp, RemoteId));
        checkWord("response data", data, dmemRdRsp);
        checkBit("dmemReady after response", 1'b1, dmemReady);
    endtask

    task automatic testBackPressure();
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] got;
        tileTrans_t  t;
        int          sent;
        curTest  = "backPressure";
        fabReady = 1'b0;
        sent     = 0;
        while (miniCoreReady && sent < 6) begin     // Fill the response queue
            addr = fabAddr(8'h01, usedIdx[sent]);
            expRsp.push_back(makeTrans({8'h40 + 8'(sent), addr[23:0]}, refMem[usedIdx[sent]],
                             RdRsp, LocalId));
            inFabricValid = 1'b1;
            inFabric      = makeTrans(addr, '0, Rd, 8'h40 + 8'(sent));
            @(negedge Clock);
            inFabricValid = 1'b0;
            sent++;
        end
        checkBit("miniCoreReady under stall", 1'b0, miniCoreReady);
        addr = coreAddr(RemoteId, usedIdx[3], 2'd0);
        data = $random(seed);
        driveCore(addr, data, 4'hF, 1'b1, 1'b0, got);
        expReq.push_back(makeTrans(addr, data, Wr, LocalId));
        repeat (4) @(negedge Clock);
        checkBit("outFabricValid under stall", 1'b0, sawValidStalled);
        checkWord("outputs under stall", 32'd0, outQ.size());
        fabReady = 1'b1;
        waitOutput(sent + 1, "drained traffic");
        repeat (4) @(negedge Clock);
        checkWord("transaction count", sent + 1, outQ.size());
        checkBit("miniCoreReady after drain", 1'b1, miniCoreReady);
        if (outQ.size() >= 2) begin
            // Responses lead since the remote read won last
            checkBit("response first", 1'b1, outQ[0].opcode == RdRsp);
            checkBit("alternation", 1'b1, outQ[0].opcode != outQ[1].opcode);
        end
        while (outQ.size() > 0) begin
            t = outQ.pop_front();
            if (t.opcode == RdRsp && expRsp.size() > 0) begin
                checkTrans("response order", expRsp.pop_front(), t);
            end else if (t.opcode == Wr && expReq.size() > 0) begin
                checkTrans("request order", expReq.pop_front(), t);
            end else begin
                $display("An unexpected transaction %h came out in %s", t, curTest);
                errors++;
            end
        end
    endtask

    //========================================
    // Main sequence and watchdog
    //========================================
    initial begin
        seed            = 32'h63fb;
        errors          = 0;
        sawValidStalled = 1'b0;
        Clock           = 1'b0;
        rstN            = 1'b0;
        localTileId     = LocalId;
        coreReq         = '0;
        inFabricValid   = 1'b0;
        inFabric        = '0;
        fabReady        = 1'b1;
        repeat (4) @(negedge Clock);
        rstN    = 1'b1;
        curTest = "reset";
        checkBit("outFabricValid", 1'b0, outFabricValid);
        checkBit("dmemReady", 1'b1, dmemReady);
        checkBit("miniCoreReady", 1'b1, miniCoreReady);
        testLocalAccess();
        testFabricWrite();
        testFabricRead();
        testRemoteWrite();
        testRemoteRead();
        testBackPressure();
        $display("Tests done with %0d errors", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WatchdogNs);
        $display("The watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

endmodule

//--- vlog.f
hdl/tilePkg.sv
hdl/dualPortRam.sv
hdl/transFifo.sv
hdl/coreDataPort.sv
hdl/fabricSlave.sv
hdl/fabricEgressArb.sv
hdl/tileMemWrap.sv
test/tileMemTb.sv
